// File: Makefile
# Verilator simulation of the TLB testbench

VERILATOR ?= verilator
TOP       ?= tb_tlb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
rtl/tlb_pkg.sv
rtl/tlb_fence_seq.sv
rtl/tlb_array.sv
rtl/tlb_resp.sv
rtl/tlb_top.sv
sim/tb_tlb.sv

// File: rtl/tlb_array.sv
`timescale 1ns/1ps

module tlb_array #(
    parameter int               DEPTH  = 8,
    parameter tlb_pkg::access_e ACCESS = tlb_pkg::ACC_STORE,
    localparam int              IDX_W  = $clog2(DEPTH)
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [2*tlb_pkg::VPN_PART_W-1:0]           key_vpn,
    input  logic [tlb_pkg::ASID_W-1:0]                 key_asid,
    input  logic                                       any_asid,
    input  logic                                       any_addr,
    input  logic                                       inv_en,
    input  logic [IDX_W-1:0]                           inv_idx,
    input  logic                                       fill_en,
    input  logic [IDX_W-1:0]                           fill_idx,
    input  logic [tlb_pkg::VADDR_W-1:0]                fill_vaddr,
    input  logic [tlb_pkg::PPN1_W+tlb_pkg::PPN0_W-1:0] fill_ppn,
    input  logic                                       fill_super,
    input  logic                                       fill_g,
    input  logic                                       fill_u,
    input  logic                                       fill_r,
    input  logic                                       fill_w,
    input  logic                                       fill_x,
    input  logic                                       fill_d,
    input  logic                                       fill_uc,
    input  logic [tlb_pkg::ASID_W-1:0]                 asid,
    output logic [DEPTH-1:0]                           hit_vec,
    output logic [DEPTH-1:0]                           valid_vec,
    output logic [IDX_W-1:0]                           hit_idx,
    output logic                                       hit,
    output logic [tlb_pkg::PPN1_W+tlb_pkg::PPN0_W-1:0] hit_ppn,
    output logic                                       hit_super,
    output logic                                       hit_u,
    output logic                                       hit_r,
    output logic                                       hit_x,
    output logic                                       hit_d,
    output logic                                       hit_exc,
    output logic                                       hit_uc
);
    import tlb_pkg::*;

    localparam int PPN_W = PPN1_W + PPN0_W;

    logic [VPN_PART_W-1:0] ent_vpn1 [DEPTH];
    logic [VPN_PART_W-1:0] ent_vpn0 [DEPTH];
    logic [PPN_W-1:0]      ent_ppn  [DEPTH];
    logic [ASID_W-1:0]     ent_asid [DEPTH];
    logic [DEPTH-1:0]      ent_super;
    logic [DEPTH-1:0]      ent_g;
    logic [DEPTH-1:0]      ent_u;
    logic [DEPTH-1:0]      ent_r;
    logic [DEPTH-1:0]      ent_x;
    logic [DEPTH-1:0]      ent_d;
    logic [DEPTH-1:0]      ent_exc;
    logic [DEPTH-1:0]      ent_uc;
    logic                  fill_exc;

    // Port-specific part of the fault, folded in at fill time
    always_comb begin
        case (ACCESS)
            ACC_FETCH: fill_exc = ~fill_x;
            ACC_LOAD:  fill_exc = 1'b0;
            default:   fill_exc = ~fill_w | ~fill_d;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_vec <= '0;
        end else if (inv_en) begin
            valid_vec[inv_idx] <= 1'b0;   // Invalidate beats fill
        end else if (fill_en) begin
            valid_vec[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en && !inv_en) begin
            ent_vpn1[fill_idx]  <= fill_vaddr[VADDR_W-1 -: VPN_PART_W];
            ent_vpn0[fill_idx]  <= fill_vaddr[OFFSET_W +: VPN_PART_W];
            ent_ppn[fill_idx]   <= fill_ppn;
            ent_asid[fill_idx]  <= asid;
            ent_super[fill_idx] <= fill_super;
            ent_g[fill_idx]     <= fill_g;
            ent_u[fill_idx]     <= fill_u;
            ent_r[fill_idx]     <= fill_r;
            ent_x[fill_idx]     <= fill_x;
            ent_d[fill_idx]     <= fill_d;
            ent_exc[fill_idx]   <= fill_exc;
            ent_uc[fill_idx]    <= fill_uc;
        end
    end

    for (genvar i = 0; i < DEPTH; i++) begin : g_match
        logic asid_ok;
        logic vpn1_ok;
        logic vpn0_ok;

        assign asid_ok = ent_g[i] | any_asid | (ent_asid[i] == key_asid);
        assign vpn1_ok = (ent_vpn1[i] == key_vpn[VPN_PART_W +: VPN_PART_W]);
        assign vpn0_ok = ent_super[i] | (ent_vpn0[i] == key_vpn[VPN_PART_W-1:0]);
        assign hit_vec[i] = valid_vec[i] & asid_ok & (any_addr | (vpn1_ok & vpn0_ok));
    end

    // Lowest index wins
    always_comb begin
        hit_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign hit       = |hit_vec;
    assign hit_ppn   = ent_ppn[hit_idx];
    assign hit_super = ent_super[hit_idx];
    assign hit_u     = ent_u[hit_idx];
    assign hit_r     = ent_r[hit_idx];
    assign hit_x     = ent_x[hit_idx];
    assign hit_d     = ent_d[hit_idx];
    assign hit_exc   = ent_exc[hit_idx];
    assign hit_uc    = ent_uc[hit_idx];

endmodule

// File: rtl/tlb_fence_seq.sv
`timescale 1ns/1ps

module tlb_fence_seq #(
    parameter int  DEPTH = 8,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [tlb_pkg::VADDR_W-1:0]        vaddr,
    input  logic [tlb_pkg::ASID_W-1:0]         asid,
    input  logic                               fence_req,
    input  logic [tlb_pkg::VADDR_W-1:0]        fence_vaddr,
    input  logic [tlb_pkg::ASID_W-1:0]         fence_asid,
    input  logic                               fence_all_addr,
    input  logic                               fence_all_asid,
    input  logic [DEPTH-1:0]                   hit_vec,
    input  logic [IDX_W-1:0]                   hit_idx,
    input  logic [DEPTH-1:0]                   valid_vec,
    output logic [2*tlb_pkg::VPN_PART_W-1:0]   key_vpn,
    output logic [tlb_pkg::ASID_W-1:0]         key_asid,
    output logic                               any_asid,
    output logic                               any_addr,
    output logic                               inv_en,
    output logic [IDX_W-1:0]                   inv_idx,
    output logic                               fence_busy
);
    import tlb_pkg::*;

    fence_state_e              state;
    logic [IDX_W-1:0]          walk_idx;
    logic [2*VPN_PART_W-1:0]   vpn_q;
    logic [ASID_W-1:0]         asid_q;
    logic                      all_addr_q;
    logic                      all_asid_q;
    logic                      running;

    assign running    = (state == FENCE_RUN);
    assign fence_busy = (state != FENCE_IDLE);

    // Fence operands stay fixed for the whole pass
    always_ff @(posedge clk) begin
        if (state == FENCE_IDLE && fence_req) begin
            vpn_q      <= fence_vaddr[VADDR_W-1:OFFSET_W];
            asid_q     <= fence_asid;
            all_addr_q <= fence_all_addr;
            all_asid_q <= fence_all_asid;
        end
    end

    // Array key is shared between lookup and fence
    assign key_vpn  = running ? vpn_q : vaddr[VADDR_W-1:OFFSET_W];
    assign key_asid = running ? asid_q : asid;
    assign any_asid = running & all_asid_q;
    assign any_addr = running & all_addr_q;

    always_comb begin
        if (all_addr_q) begin
            inv_en  = running & valid_vec[walk_idx] & hit_vec[walk_idx];
            inv_idx = walk_idx;
        end else begin
            inv_en  = running & (|hit_vec);   // Lowest matching entry only
            inv_idx = hit_idx;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= FENCE_IDLE;
            walk_idx <= '0;
        end else begin
            case (state)
                FENCE_IDLE: begin
                    if (fence_req) begin
                        state    <= FENCE_RUN;
                        walk_idx <= '0;
                    end
                end
                FENCE_RUN: begin
                    if (!all_addr_q || walk_idx == IDX_W'(DEPTH - 1)) begin
                        state    <= FENCE_END;
                        walk_idx <= '0;
                    end else begin
                        walk_idx <= walk_idx + 1'b1;
                    end
                end
                FENCE_END: begin
                    // Two drain cycles, counted on the walk counter
                    if (walk_idx[0]) begin
                        state <= FENCE_IDLE;
                    end
                    walk_idx <= walk_idx + 1'b1;
                end
                default: begin
                    state <= FENCE_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/tlb_pkg.sv
package tlb_pkg;

    // Sv32 address geometry
    localparam int VADDR_W    = 32;
    localparam int PADDR_W    = 34;
    localparam int OFFSET_W   = 12;
    localparam int VPN_PART_W = 10;   // Each of vpn[1], vpn[0]
    localparam int PPN1_W     = 12;
    localparam int PPN0_W     = 10;
    localparam int ASID_W     = 9;

    // Current privilege level, as encoded in mstatus.MPP
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    // Which pipeline port a TLB instance serves
    typedef enum logic [1:0] {
        ACC_FETCH = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_e;

    typedef enum logic [1:0] {
        FENCE_IDLE = 2'd0,
        FENCE_RUN  = 2'd1,   // Invalidate pass
        FENCE_END  = 2'd2    // Drain before lookups resume
    } fence_state_e;

endpackage

// File: rtl/tlb_resp.sv
`timescale 1ns/1ps

module tlb_resp #(
    parameter tlb_pkg::access_e ACCESS = tlb_pkg::ACC_STORE
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       req,
    input  logic [tlb_pkg::VADDR_W-1:0]                vaddr,
    input  tlb_pkg::priv_e                             priv,
    input  logic                                       satp_on,
    input  logic                                       sum,
    input  logic                                       mxr,
    input  logic                                       hit,
    input  logic [tlb_pkg::PPN1_W+tlb_pkg::PPN0_W-1:0] hit_ppn,
    input  logic                                       hit_super,
    input  logic                                       hit_u,
    input  logic                                       hit_r,
    input  logic                                       hit_x,
    input  logic                                       hit_d,
    input  logic                                       hit_exc,
    input  logic                                       hit_uc,
    output logic [tlb_pkg::PADDR_W-1:0]                paddr,
    output logic                                       miss,
    output logic                                       exception,
    output logic                                       uncache
);
    import tlb_pkg::*;

    logic               bare;
    logic               u_fault;
    logic               r_fault;
    logic               d_fault;
    logic               fault;
    logic [PPN0_W-1:0]  ppn0;
    logic [PADDR_W-1:0] xlate_paddr;
    logic [PADDR_W-1:0] bare_paddr;

    assign bare = (priv == PRIV_M) | ~satp_on;

    // U pages need SUM from S mode, S pages are closed to U mode
    assign u_fault = ((priv == PRIV_U) & ~hit_u) | ((priv == PRIV_S) & hit_u & ~sum);
    assign r_fault = (ACCESS != ACC_FETCH) & ~hit_r & ~(hit_x & mxr);
    assign d_fault = (ACCESS == ACC_STORE) & ~hit_d;
    assign fault   = u_fault | r_fault | d_fault | hit_exc;

    // Superpage takes vpn[0] in place of ppn[0]
    assign ppn0 = hit_super ? vaddr[OFFSET_W +: VPN_PART_W] : hit_ppn[PPN0_W-1:0];

    assign xlate_paddr = {hit_ppn[PPN0_W +: PPN1_W], ppn0, vaddr[OFFSET_W-1:0]};
    assign bare_paddr  = {{(PADDR_W - VADDR_W){1'b0}}, vaddr};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            miss      <= 1'b0;
            exception <= 1'b0;
        end else begin
            miss      <= req & ~bare & ~hit;
            exception <= req & ~bare & hit & fault;
        end
    end

    // Held until the next lookup
    always_ff @(posedge clk) begin
        if (req) begin
            paddr   <= bare ? bare_paddr : xlate_paddr;
            uncache <= ~bare & hit_uc;
        end
    end

endmodule

// File: rtl/tlb_top.sv
`timescale 1ns/1ps

module tlb_top #(
    parameter int               DEPTH  = 8,
    parameter tlb_pkg::access_e ACCESS = tlb_pkg::ACC_STORE,
    localparam int              IDX_W  = $clog2(DEPTH)
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       req,
    input  logic [tlb_pkg::VADDR_W-1:0]                vaddr,
    input  tlb_pkg::priv_e                             priv,
    input  logic                                       satp_on,
    input  logic [tlb_pkg::ASID_W-1:0]                 asid,
    input  logic                                       sum,
    input  logic                                       mxr,
    input  logic                                       fill_en,
    input  logic [IDX_W-1:0]                           fill_idx,
    input  logic [tlb_pkg::VADDR_W-1:0]                fill_vaddr,
    input  logic [tlb_pkg::PPN1_W+tlb_pkg::PPN0_W-1:0] fill_ppn,
    input  logic                                       fill_super,
    input  logic                                       fill_g,
    input  logic                                       fill_u,
    input  logic                                       fill_r,
    input  logic                                       fill_w,
    input  logic                                       fill_x,
    input  logic                                       fill_d,
    input  logic                                       fill_uc,
    input  logic                                       fence_req,
    input  logic [tlb_pkg::VADDR_W-1:0]                fence_vaddr,
    input  logic [tlb_pkg::ASID_W-1:0]                 fence_asid,
    input  logic                                       fence_all_addr,
    input  logic                                       fence_all_asid,
    output logic [tlb_pkg::PADDR_W-1:0]                paddr,
    output logic                                       miss,
    output logic                                       exception,
    output logic                                       uncache,
    output logic                                       fence_busy
);
    import tlb_pkg::*;

    logic [2*VPN_PART_W-1:0]     key_vpn;
    logic [ASID_W-1:0]           key_asid;
    logic                        any_asid;
    logic                        any_addr;
    logic                        inv_en;
    logic [IDX_W-1:0]            inv_idx;
    logic [DEPTH-1:0]            hit_vec;
    logic [DEPTH-1:0]            valid_vec;
    logic [IDX_W-1:0]            hit_idx;
    logic                        hit;
    logic [PPN1_W+PPN0_W-1:0]    hit_ppn;
    logic                        hit_super;
    logic                        hit_u;
    logic                        hit_r;
    logic                        hit_x;
    logic                        hit_d;
    logic                        hit_exc;
    logic                        hit_uc;

    tlb_fence_seq #(
        .DEPTH (DEPTH)
    ) u_fence_seq (
        .clk            (clk),
        .rst            (rst),
        .vaddr          (vaddr),
        .asid           (asid),
        .fence_req      (fence_req),
        .fence_vaddr    (fence_vaddr),
        .fence_asid     (fence_asid),
        .fence_all_addr (fence_all_addr),
        .fence_all_asid (fence_all_asid),
        .hit_vec        (hit_vec),
        .hit_idx        (hit_idx),
        .valid_vec      (valid_vec),
        .key_vpn        (key_vpn),
        .key_asid       (key_asid),
        .any_asid       (any_asid),
        .any_addr       (any_addr),
        .inv_en         (inv_en),
        .inv_idx        (inv_idx),
        .fence_busy     (fence_busy)
    );

    tlb_array #(
        .DEPTH  (DEPTH),
        .ACCESS (ACCESS)
    ) u_array (
        .clk        (clk),
        .rst        (rst),
        .key_vpn    (key_vpn),
        .key_asid   (key_asid),
        .any_asid   (any_asid),
        .any_addr   (any_addr),
        .inv_en     (inv_en),
        .inv_idx    (inv_idx),
        .fill_en    (fill_en),
        .fill_idx   (fill_idx),
        .fill_vaddr (fill_vaddr),
        .fill_ppn   (fill_ppn),
        .fill_super (fill_super),
        .fill_g     (fill_g),
        .fill_u     (fill_u),
        .fill_r     (fill_r),
        .fill_w     (fill_w),
        .fill_x     (fill_x),
        .fill_d     (fill_d),
        .fill_uc    (fill_uc),
        .asid       (asid),
        .hit_vec    (hit_vec),
        .valid_vec  (valid_vec),
        .hit_idx    (hit_idx),
        .hit        (hit),
        .hit_ppn    (hit_ppn),
        .hit_super  (hit_super),
        .hit_u      (hit_u),
        .hit_r      (hit_r),
        .hit_x      (hit_x),
        .hit_d      (hit_d),
        .hit_exc    (hit_exc),
        .hit_uc     (hit_uc)
    );

    tlb_resp #(
        .ACCESS (ACCESS)
    ) u_resp (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .vaddr     (vaddr),
        .priv      (priv),
        .satp_on   (satp_on),
        .sum       (sum),
        .mxr       (mxr),
        .hit       (hit),
        .hit_ppn   (hit_ppn),
        .hit_super (hit_super),
        .hit_u     (hit_u),
        .hit_r     (hit_r),
        .hit_x     (hit_x),
        .hit_d     (hit_d),
        .hit_exc   (hit_exc),
        .hit_uc    (hit_uc),
        .paddr     (paddr),
        .miss      (miss),
        .exception (exception),
        .uncache   (uncache)
    );

endmodule

// File: sim/tb_tlb.sv
`timescale 1ns/1ps

module tb_tlb;
    import tlb_pkg::*;

    localparam int      DEPTH    = 8;
    localparam access_e PORT     = ACC_STORE;
    localparam int      IDX_W    = $clog2(DEPTH);
    localparam int      N_RAND   = 32;   // Lookups per random test
    localparam int      N_SFENCE = 4;
    localparam int      N_AFENCE = 2;
    // Lookups and fills take one cycle, a fence at most DEPTH+3
    localparam int N_OPS      = 4 * N_RAND + 2 * DEPTH + (N_SFENCE + N_AFENCE) * (2 * DEPTH + 1);
    localparam int MAX_CYCLES = N_OPS * (DEPTH + 3) + 100;

    logic clk;
    logic rst;
    logic req;
    logic [VADDR_W-1:0] vaddr;
    priv_e priv;
    logic satp_on;
    logic [ASID_W-1:0] asid;
    logic sum;
    logic mxr;
    logic fill_en;
    logic [IDX_W-1:0] fill_idx;
    logic [VADDR_W-1:0] fill_vaddr;
    logic [PPN1_W+PPN0_W-1:0] fill_ppn;
    logic fill_super, fill_g, fill_u, fill_r, fill_w, fill_x, fill_d, fill_uc;
    logic fence_req;
    logic [VADDR_W-1:0] fence_vaddr;
    logic [ASID_W-1:0] fence_asid;
    logic fence_all_addr;
    logic fence_all_asid;
    logic [PADDR_W-1:0] paddr;
    logic miss, exception, uncache, fence_busy;

    // Reference copy of the entry array
    logic [DEPTH-1:0] m_valid, m_super, m_g, m_u, m_r, m_w, m_x, m_d, m_uc;
    logic [VPN_PART_W-1:0]    m_vpn1 [DEPTH];
    logic [VPN_PART_W-1:0]    m_vpn0 [DEPTH];
    logic [PPN1_W+PPN0_W-1:0] m_ppn  [DEPTH];
    logic [ASID_W-1:0]        m_asid [DEPTH];

    logic [31:0] lfsr = 32'hac76135a;
    int checks = 0;
    int fails = 0;
    int mark_checks = 0;
    int mark_fails = 0;
    int cycle_count = 0;

    tlb_top #(.DEPTH(DEPTH), .ACCESS(PORT)) dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run went past %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[31]};
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
        end
        return v;
    endfunction

    function automatic int model_match(logic [2*VPN_PART_W-1:0] vpn, logic [ASID_W-1:0] as,
                                       logic all_asid);
        int found;
        found = -1;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (m_valid[i] && (m_g[i] || all_asid || m_asid[i] == as) &&
                m_vpn1[i] == vpn[2*VPN_PART_W-1:VPN_PART_W] &&
                (m_super[i] || m_vpn0[i] == vpn[VPN_PART_W-1:0])) begin
                found = i;
            end
        end
        return found;
    endfunction

    function automatic logic expect_fault(int i, priv_e pv, logic s_um, logic m_xr);
        logic f;
        case (PORT)
            ACC_FETCH: f = !m_x[i];
            ACC_LOAD:  f = 1'b0;
            default:   f = !m_w[i] || !m_d[i];
        endcase
        if (pv == PRIV_U && !m_u[i]) f = 1'b1;
        if (pv == PRIV_S && m_u[i] && !s_um) f = 1'b1;
        if (PORT != ACC_FETCH && !m_r[i] && !(m_x[i] && m_xr)) f = 1'b1;
        if (PORT == ACC_STORE && !m_d[i]) f = 1'b1;
        return f;
    endfunction

    // Address that should land on entry i
    function automatic logic [VADDR_W-1:0] entry_vaddr(int i);
        return {m_vpn1[i], m_super[i] ? 10'(rand_bits(10)) : m_vpn0[i], 12'(rand_bits(12))};
    endfunction

    function automatic logic [ASID_W-1:0] entry_asid(int i);
        return m_g[i] ? 9'(rand_bits(2)) : m_asid[i];
    endfunction

    task automatic fill_entry(int i);
        fill_idx   = IDX_W'(i);
        fill_vaddr = rand_bits(32);
        fill_ppn   = 22'(rand_bits(22));
        fill_super = (rand_bits(2) == 0);
        fill_g     = (rand_bits(2) == 0);
        fill_u     = 1'(rand_bits(1));
        fill_r     = 1'(rand_bits(1));
        fill_w     = (rand_bits(2) != 0);
        fill_x     = 1'(rand_bits(1));
        fill_d     = (rand_bits(2) != 0);
        fill_uc    = 1'(rand_bits(1));
        asid       = 9'(rand_bits(2));   // Small ASID space forces overlaps
        fill_en    = 1'b1;
        @(posedge clk);
        #2;
        fill_en    = 1'b0;
        m_valid[i] = 1'b1;
        m_vpn1[i]  = fill_vaddr[31:22];
        m_vpn0[i]  = fill_vaddr[21:12];
        m_ppn[i]   = fill_ppn;
        m_asid[i]  = asid;
        {m_super[i], m_g[i], m_u[i], m_r[i]} = {fill_super, fill_g, fill_u, fill_r};
        {m_w[i], m_x[i], m_d[i], m_uc[i]}    = {fill_w, fill_x, fill_d, fill_uc};
    endtask

    task automatic lookup_check(logic [VADDR_W-1:0] va, logic [ASID_W-1:0] as, priv_e pv,
                                logic sat, logic s_um, logic m_xr);
        int idx;
        logic [PADDR_W-1:0] exp_pa;
        logic exp_miss, exp_exc, exp_uc;
        idx      = model_match(va[VADDR_W-1:OFFSET_W], as, 1'b0);
        exp_pa   = {2'b00, va};
        exp_miss = 1'b0;
        exp_exc  = 1'b0;
        exp_uc   = 1'b0;
        if (pv != PRIV_M && sat) begin
            exp_miss = (idx < 0);
            if (idx >= 0) begin
                exp_exc = expect_fault(idx, pv, s_um, m_xr);
                exp_uc  = m_uc[idx];
                exp_pa  = {m_ppn[idx][21:10], m_super[idx] ? va[21:12] : m_ppn[idx][9:0],
                           va[11:0]};
            end
        end
        {req, vaddr, asid, satp_on, sum, mxr} = {1'b1, va, as, sat, s_um, m_xr};
        priv = pv;
        @(posedge clk);
        #2;
        req = 1'b0;
        checks += 5;
        if (miss !== exp_miss) begin
            $display("FAILED miss: expected %h, got %h", exp_miss, miss);
            fails++;
        end
        if (exception !== exp_exc) begin
            $display("FAILED exception: expected %h, got %h", exp_exc, exception);
            fails++;
        end
        if (miss === 1'b1 && exception === 1'b1) begin
            $display("Miss and exception were high in the same cycle");
            fails++;
        end
        if (!exp_miss && paddr !== exp_pa) begin
            $display("FAILED paddr: expected %h, got %h", exp_pa, paddr);
            fails++;
        end
        if (!exp_miss && uncache !== exp_uc) begin
            $display("FAILED uncache: expected %h, got %h", exp_uc, uncache);
            fails++;
        end
    endtask

    task automatic run_fence(logic [VADDR_W-1:0] fv, logic [ASID_W-1:0] fa, logic all_addr,
                             logic all_as);
        int idx;
        int busy_cycles;
        int exp_cycles;
        {fence_vaddr, fence_asid, fence_all_addr, fence_all_asid} = {fv, fa, all_addr, all_as};
        fence_req = 1'b1;
        @(posedge clk);
        #2;
        fence_req = 1'b0;
        idx = model_match(fv[VADDR_W-1:OFFSET_W], fa, all_as);
        for (int i = 0; i < DEPTH; i++) begin
            if (all_addr ? (m_g[i] || all_as || m_asid[i] == fa) : (i == idx)) m_valid[i] = 1'b0;
        end
        exp_cycles  = all_addr ? DEPTH + 2 : 3;
        busy_cycles = 0;
        checks += 2;
        if (fence_busy !== 1'b1) begin
            $display("fence_busy did not rise after a fence request");
            fails++;
        end
        while (fence_busy === 1'b1 && busy_cycles <= 4 * DEPTH) begin
            @(posedge clk);
            #2;
            busy_cycles++;
        end
        if (busy_cycles != exp_cycles) begin
            $display("FAILED fence_busy length: expected %h, got %h", exp_cycles, busy_cycles);
            fails++;
        end
    endtask

    task automatic sweep_entries();
        for (int i = 0; i < DEPTH; i++) lookup_check(entry_vaddr(i), entry_asid(i), PRIV_S,
                                                     1'b1, 1'b1, 1'b1);
    endtask

    task automatic end_test(int num, string name);
        $display("Test %0d %s: %0d checks, %0d failed", num, name, checks - mark_checks,
                 fails - mark_fails);
        mark_checks = checks;
        mark_fails  = fails;
    endtask

    initial begin
        priv_e pv;
        int e;
        {rst, req, vaddr, satp_on, asid, sum, mxr} = '0;
        priv = PRIV_M;
        {fill_en, fill_idx, fill_vaddr, fill_ppn} = '0;
        {fill_super, fill_g, fill_u, fill_r, fill_w, fill_x, fill_d, fill_uc} = '0;
        {fence_req, fence_vaddr, fence_asid, fence_all_addr, fence_all_asid} = '0;
        m_valid = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;

        for (int n = 0; n < N_RAND; n++) begin
            pv = rand_bits(1) ? PRIV_M : PRIV_S;
            lookup_check(rand_bits(32), 9'(rand_bits(2)), pv,
                         (pv == PRIV_M) ? 1'(rand_bits(1)) : 1'b0, 1'b1, 1'b1);
        end
        end_test(1, "bare mode");

        for (int i = 0; i < DEPTH; i++) fill_entry(i);
        for (int n = 0; n < N_RAND; n++) begin
            e = int'(rand_bits(IDX_W));
            lookup_check(entry_vaddr(e), entry_asid(e), PRIV_S, 1'b1, 1'b1, 1'(rand_bits(1)));
        end
        end_test(2, "translation");

        for (int n = 0; n < N_RAND; n++) begin
            e = int'(rand_bits(IDX_W));
            lookup_check(rand_bits(1) ? rand_bits(32) : entry_vaddr(e), 9'(rand_bits(2)),
                         PRIV_S, 1'b1, 1'b1, 1'b0);
        end
        end_test(3, "misses");

        for (int i = 0; i < DEPTH; i++) fill_entry(i);
        for (int n = 0; n < N_RAND; n++) begin
            e  = int'(rand_bits(IDX_W));
            pv = rand_bits(1) ? PRIV_U : PRIV_S;
            lookup_check(entry_vaddr(e), entry_asid(e), pv, 1'b1, 1'(rand_bits(1)),
                         1'(rand_bits(1)));
        end
        end_test(4, "permission faults");

        for (int n = 0; n < N_SFENCE; n++) begin
            for (int i = 0; i < DEPTH; i++) fill_entry(i);
            e = int'(rand_bits(IDX_W));
            run_fence((rand_bits(2) == 0) ? rand_bits(32) : entry_vaddr(e),
                      rand_bits(1) ? m_asid[e] : 9'(rand_bits(2)), 1'b0, (rand_bits(2) == 0));
            sweep_entries();
        end
        end_test(5, "single-address fence");

        for (int n = 0; n < N_AFENCE; n++) begin
            for (int i = 0; i < DEPTH; i++) fill_entry(i);
            run_fence(rand_bits(32), 9'(rand_bits(2)), 1'b1, (n == 0));
            sweep_entries();
        end
        end_test(6, "all-address fence");

        $display("Checks: %0d passed, %0d failed", checks - fails, fails);
        if (fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
